//--- src/fl_cfg.svh
`ifndef FL_CFG_SVH
`define FL_CFG_SVH

// Data word.
`define FL_WIDTH    16

// Buffer address space.
`define FL_BITADDR  6
`define FL_NUMADDR  64

// Banking of the data store.
`define FL_BITVBNK  2
`define FL_NUMVBNK  4
`define FL_BITVROW  4

// Free count must reach FL_NUMADDR.
`define FL_BITCNT   7

`endif

//--- src/fl_pkg.sv
`default_nettype none

`include "fl_cfg.svh"

package fl_pkg;

  // Virtual view, row above bank.
  typedef struct packed {
    logic [`FL_BITVROW-1:0] row;
    logic [`FL_BITVBNK-1:0] bank;
  } fl_vrow_s;

  // One buffer address, seen flat or split into bank and row.
  typedef union packed {
    logic [`FL_BITADDR-1:0] flat;
    fl_vrow_s               vrow;
  } fl_vaddr_u;

  // Physical address as reported on the read port.
  typedef struct packed {
    logic [`FL_BITVBNK-1:0] bank;
    logic [`FL_BITVROW-1:0] row;
  } fl_padr_s;

endpackage

`default_nettype wire

//--- src/fl_if.sv
`default_nettype none

`include "fl_cfg.svh"

interface fl_if;

  logic                   ready;
  logic                   push;
  logic [`FL_BITADDR-1:0] push_adr;
  logic                   pop;
  logic [`FL_BITADDR-1:0] pop_adr;
  logic                   empty;

  modport fsm_mp (output ready, push, push_adr);

  modport list_mp (input ready, push, push_adr, empty, output pop, pop_adr);

  modport cnt_mp (input push, pop, output empty);

  modport mem_mp (input pop, pop_adr);

endinterface

`default_nettype wire

//--- src/fl_init_fsm.sv
`default_nettype none

`include "fl_cfg.svh"

module fl_init_fsm (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  fl_if.fsm_mp                        f,
  input  wire logic                   dq_vld,
  input  wire logic [`FL_BITADDR-1:0] dq_adr,
  input  wire logic [`FL_BITADDR-1:0] fill_idx,
  input  wire logic                   fill_last
);

  typedef enum logic {
    FILL,
    RUN
  } state_t;

  state_t state;
  state_t state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      FILL: if (fill_last) state_nxt = RUN; // Last address pushed this cycle.
      RUN:  state_nxt = RUN;
      default: state_nxt = FILL;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= FILL;
    end else begin
      state <= state_nxt;
    end
  end

  // Fill pushes every address once, then dequeues take over.
  always_comb begin
    if (state == FILL) begin
      f.push     = 1'b1;
      f.push_adr = fill_idx;
    end else begin
      f.push     = dq_vld;
      f.push_adr = dq_adr;
    end
  end

  assign f.ready = (state == RUN);

endmodule

`default_nettype wire

//--- src/fl_count.sv
`default_nettype none

`include "fl_cfg.svh"

module fl_count (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  fl_if.cnt_mp                        f,
  input  wire logic [`FL_BITCNT-1:0]  bp_thr,
  output logic      [`FL_BITADDR-1:0] fill_idx,
  output logic                        fill_last,
  output logic                        ma_bp
);

  logic [`FL_BITCNT-1:0] count;
  logic                  fill_done;
  logic                  fill_en;

  // Free entries.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({f.push, f.pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither.
      endcase
    end
  end

  assign fill_en   = !fill_done && (count < `FL_NUMADDR);
  assign fill_last = fill_en && (fill_idx == `FL_BITADDR'(`FL_NUMADDR - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_idx  <= '0;
      fill_done <= 1'b0;
    end else begin
      if (fill_en) fill_idx <= fill_idx + 1'b1;
      if (fill_last) fill_done <= 1'b1;
    end
  end

  assign f.empty = (count == '0);

  // Quiet until the list has been filled.
  assign ma_bp = fill_done && (count <= bp_thr);

endmodule

`default_nettype wire

//--- src/free_list.sv
`default_nettype none

`include "fl_cfg.svh"

module free_list (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  fl_if.list_mp                       f,
  input  wire logic                   malloc,
  output logic      [`FL_BITADDR-1:0] ma_adr
);

  logic [`FL_BITADDR-1:0] list_mem [`FL_NUMADDR];
  logic [`FL_BITADDR-1:0] head;
  logic [`FL_BITADDR-1:0] tail;

  // Only an empty list blocks a malloc.
  assign f.pop = malloc && f.ready && !f.empty;

  assign f.pop_adr = list_mem[head];
  assign ma_adr    = list_mem[head]; // Valid only while not empty.

  // Pointers wrap naturally at 64 entries.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (f.pop) begin
        head <= head + 1'b1;
      end
      if (f.push) begin
        tail <= tail + 1'b1;
      end
    end
  end

  // Append at tail.
  always_ff @(posedge clk) begin
    if (f.push) begin
      list_mem[tail] <= f.push_adr;
    end
  end

endmodule

`default_nettype wire

//--- src/bank_array.sv
`default_nettype none

`include "fl_cfg.svh"

module bank_array
  import fl_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  fl_if.mem_mp                        f,
  input  wire logic [`FL_WIDTH-1:0]   ma_din,
  input  wire logic                   read,
  input  wire logic [`FL_BITADDR-1:0] rd_adr,
  output logic                        rd_vld,
  output logic      [`FL_WIDTH-1:0]   rd_dout,
  output fl_padr_s                    rd_padr
);

  localparam int NUMVROW = 1 << `FL_BITVROW;

  logic [`FL_WIDTH-1:0] mem [`FL_NUMVBNK][NUMVROW];

  fl_vaddr_u             wr_va;
  fl_vaddr_u             rd_va;
  logic [`FL_NUMVBNK-1:0] bank_we;

  assign wr_va.flat = f.pop_adr;
  assign rd_va.flat = rd_adr;

  // One-hot bank write enable.
  always_comb begin
    bank_we = '0;
    if (f.pop) begin
      bank_we[wr_va.vrow.bank] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < `FL_NUMVBNK; b++) begin
      if (bank_we[b]) begin
        mem[b][wr_va.vrow.row] <= ma_din;
      end
    end
  end

  // Read sees the old word on a same-cycle write.
  always_ff @(posedge clk) begin
    if (read) begin
      rd_dout      <= mem[rd_va.vrow.bank][rd_va.vrow.row];
      rd_padr.bank <= rd_va.vrow.bank;
      rd_padr.row  <= rd_va.vrow.row;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= read; // One cycle after the request.
    end
  end

endmodule

`default_nettype wire

//--- src/fl_mem_top.sv
`default_nettype none

`include "fl_cfg.svh"

module fl_mem_top (
  input  wire logic                               clk,
  input  wire logic                               rst_n,
  input  wire logic                               malloc,
  input  wire logic [`FL_WIDTH-1:0]               ma_din,
  input  wire logic                               dq_vld,
  input  wire logic [`FL_BITADDR-1:0]             dq_adr,
  input  wire logic                               read,
  input  wire logic [`FL_BITADDR-1:0]             rd_adr,
  input  wire logic [`FL_BITCNT-1:0]              bp_thr,
  output logic                                    ready,
  output logic      [`FL_BITADDR-1:0]             ma_adr,
  output logic                                    ma_bp,
  output logic                                    rd_vld,
  output logic      [`FL_WIDTH-1:0]               rd_dout,
  output logic      [`FL_BITVBNK+`FL_BITVROW-1:0] rd_padr
);

  logic [`FL_BITADDR-1:0] fill_idx;
  logic                   fill_last;

  fl_if fl_bus ();

  assign ready = fl_bus.ready;

  fl_init_fsm u_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .f         (fl_bus.fsm_mp),
    .dq_vld    (dq_vld),
    .dq_adr    (dq_adr),
    .fill_idx  (fill_idx),
    .fill_last (fill_last)
  );

  fl_count u_count (
    .clk       (clk),
    .rst_n     (rst_n),
    .f         (fl_bus.cnt_mp),
    .bp_thr    (bp_thr),
    .fill_idx  (fill_idx),
    .fill_last (fill_last),
    .ma_bp     (ma_bp)
  );

  free_list u_list (
    .clk    (clk),
    .rst_n  (rst_n),
    .f      (fl_bus.list_mp),
    .malloc (malloc),
    .ma_adr (ma_adr)
  );

  bank_array u_banks (
    .clk     (clk),
    .rst_n   (rst_n),
    .f       (fl_bus.mem_mp),
    .ma_din  (ma_din),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_padr (rd_padr)
  );

endmodule

`default_nettype wire

//--- test/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release on a falling edge, clear of the flops.
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- test/tb_fl_mem_top.sv
`default_nettype none

`include "fl_cfg.svh"

module tb_fl_mem_top;

  localparam string STIM_FILE = "test/fl_stim.txt";

  localparam logic [15:0] OP_IDLE       = 16'h0;
  localparam logic [15:0] OP_MALLOC     = 16'h1;
  localparam logic [15:0] OP_MALLOC_RND = 16'h2;
  localparam logic [15:0] OP_READ       = 16'h3;
  localparam logic [15:0] OP_DEQ        = 16'h4;
  localparam logic [15:0] OP_THR        = 16'h5;
  localparam logic [15:0] OP_BURST      = 16'h6;

  logic                              clk;
  logic                              rst_n;
  logic                              malloc;
  logic [`FL_WIDTH-1:0]              ma_din;
  logic                              dq_vld;
  logic [`FL_BITADDR-1:0]            dq_adr;
  logic                              read;
  logic [`FL_BITADDR-1:0]            rd_adr;
  logic [`FL_BITCNT-1:0]             bp_thr;
  logic                              ready;
  logic [`FL_BITADDR-1:0]            ma_adr;
  logic                              ma_bp;
  logic                              rd_vld;
  logic [`FL_WIDTH-1:0]              rd_dout;
  logic [`FL_BITVBNK+`FL_BITVROW-1:0] rd_padr;

  // Stimulus columns.
  logic [15:0] st_op[$];
  logic [15:0] st_arg[$];
  logic [15:0] st_data[$];
  logic [15:0] st_exp[$];

  logic [`FL_BITADDR-1:0] free_q[$]; // Free list model, head at index 0.
  logic [`FL_WIDTH-1:0]   mem_model [`FL_NUMADDR];
  logic [`FL_BITCNT-1:0]  thr_model;

  logic                   rd_pend;
  logic [`FL_WIDTH-1:0]   rd_exp_data;
  logic [5:0]             rd_exp_padr;
  logic [`FL_BITADDR-1:0] rd_adr_q;

  int err_cnt     = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 1000;
  int n_steps     = 0;

  tb_clk_gen #(.PERIOD(40), .RST_CYCLES(5)) u_clk (.clk(clk), .rst_n(rst_n));

  fl_mem_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .malloc  (malloc),
    .ma_din  (ma_din),
    .dq_vld  (dq_vld),
    .dq_adr  (dq_adr),
    .read    (read),
    .rd_adr  (rd_adr),
    .bp_thr  (bp_thr),
    .ready   (ready),
    .ma_adr  (ma_adr),
    .ma_bp   (ma_bp),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_padr (rd_padr)
  );

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "first mismatch");
    end
  endtask

  // Bank from the low address bits, row from the high ones.
  function automatic logic [5:0] phys_adr(input logic [`FL_BITADDR-1:0] a);
    return {a[`FL_BITVBNK-1:0], a[`FL_BITADDR-1:`FL_BITVBNK]};
  endfunction

  task automatic load_stim();
    int          fd;
    int          n;
    string       line;
    logic [15:0] op;
    logic [15:0] arg;
    logic [15:0] data;
    logic [15:0] exp;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file %s", STIM_FILE);
      $display("RESULT: FAIL");
      $fatal(1, "no stimulus");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%h %h %h %h", op, arg, data, exp);
          if (n == 4) begin
            st_op.push_back(op);
            st_arg.push_back(arg);
            st_data.push_back(data);
            st_exp.push_back(exp);
            n_steps += (op == OP_BURST) ? int'(arg) : 1;
          end else if (n > 0) begin
            $display("Malformed stimulus line: %s", line);
            $display("RESULT: FAIL");
            $fatal(1, "bad stimulus");
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Outputs sampled mid-cycle.
  task automatic check_outputs();
    check_val(rd_vld, rd_pend, "rd_vld");
    if (rd_pend) begin
      check_val(rd_dout, rd_exp_data, "rd_dout");
      check_val(rd_padr, rd_exp_padr, "rd_padr");
      check_val(rd_padr, phys_adr(rd_adr_q), "rd_padr bank and row");
    end
    check_val(ready, 1'b1, "ready");
    check_val(ma_bp, (free_q.size() <= int'(thr_model)), "ma_bp");
  endtask

  task automatic do_step(input logic [15:0] op, input logic [15:0] arg,
                         input logic [15:0] data, input logic [15:0] exp, input logic first);
    logic                   m;
    logic                   dq;
    logic                   rd;
    logic [`FL_WIDTH-1:0]   d;
    logic [`FL_BITADDR-1:0] a;
    logic [`FL_WIDTH-1:0]   old_word;
    m  = (op == OP_MALLOC) || (op == OP_MALLOC_RND);
    dq = (op == OP_DEQ);
    rd = (op == OP_READ);
    d  = (op == OP_MALLOC) ? data : 16'($urandom);
    a  = arg[`FL_BITADDR-1:0];
    if (op == OP_THR) thr_model = arg[`FL_BITCNT-1:0];
    @(posedge clk);
    malloc <= m;
    ma_din <= d;
    dq_vld <= dq;
    dq_adr <= a;
    read   <= rd;
    rd_adr <= a;
    bp_thr <= thr_model;
    @(negedge clk);
    check_outputs();
    old_word = mem_model[a]; // Read before this cycle's write.
    if (m) begin
      if (free_q.size() > 0) begin
        check_val(ma_adr, free_q[0], "ma_adr against model head");
        if (first) check_val(ma_adr, exp, "ma_adr");
        mem_model[free_q[0]] = d;
        void'(free_q.pop_front());
      end else if (first) begin
        check_val(`FL_NUMADDR, exp, "stimulus address on an empty list");
      end
    end
    if (dq) free_q.push_back(a);
    rd_pend     = rd;
    rd_exp_data = old_word;
    rd_exp_padr = exp[5:0];
    rd_adr_q    = a;
  endtask

  task automatic wait_ready();
    int fill_cycles;
    fill_cycles = 0;
    wait (rst_n === 1'b1);
    check_val(ready, 1'b0, "ready before fill");
    do begin
      @(posedge clk);
      fill_cycles++;
      @(negedge clk);
    end while (ready !== 1'b1);
    check_val(fill_cycles, `FL_NUMADDR, "fill cycles before ready");
    if (bp_thr < `FL_NUMADDR) check_val(ma_bp, 1'b0, "ma_bp at ready");
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    void'($urandom(32'hd8812e26));
    malloc    = 1'b0;
    ma_din    = '0;
    dq_vld    = 1'b0;
    dq_adr    = '0;
    read      = 1'b0;
    rd_adr    = '0;
    bp_thr    = 7'd4;
    thr_model = 7'd4;
    rd_pend   = 1'b0;
    load_stim();
    cycle_limit = `FL_NUMADDR + 2 * n_steps + 50;
    @(posedge clk);
    @(negedge clk);
    check_val(ready, 1'b0, "ready in reset");
    check_val(ma_bp, 1'b0, "ma_bp in reset");
    check_val(rd_vld, 1'b0, "rd_vld in reset");
    wait_ready();
    for (int i = 0; i < `FL_NUMADDR; i++) free_q.push_back(i[`FL_BITADDR-1:0]);
    for (int i = 0; i < st_op.size(); i++) begin
      if (st_op[i] == OP_BURST) begin
        for (int k = 0; k < int'(st_arg[i]); k++) begin
          do_step(OP_MALLOC_RND, 16'h0, 16'h0, st_exp[i], k == 0);
        end
      end else begin
        do_step(st_op[i], st_arg[i], st_data[i], st_exp[i], 1'b1);
      end
    end
    do_step(OP_IDLE, 16'h0, 16'h0, 16'h0, 1'b1); // Drains a last read.
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/fl_stim.txt
# op arg data exp, all hex. exp is ma_adr for malloc (40 = list empty), rd_padr for read.
# op 0 idle, 1 malloc, 2 malloc random data, 3 read, 4 dequeue, 5 threshold, 6 malloc burst.
5 3e 0000 00
1 00 1111 00
1 00 2222 01
1 00 3333 02
1 00 4444 03
0 00 0000 00
3 00 0000 00
3 01 0000 10
3 02 0000 20
3 03 0000 30
2 00 0000 04
3 04 0000 01
4 02 0000 00
4 00 0000 00
0 00 0000 00
5 05 0000 00
6 3b 0000 05
1 00 aaaa 02
1 00 bbbb 00
1 00 cccc 40
2 00 0000 40
3 02 0000 20
3 00 0000 00
4 07 0000 00
1 00 dddd 07
4 21 0000 00
4 3f 0000 00
4 05 0000 00
0 00 0000 00
5 02 0000 00
1 00 1234 21
3 07 0000 31
1 00 5678 3f
3 21 0000 18
3 3f 0000 3f
2 00 0000 05
3 05 0000 11
0 00 0000 00
3 3f 0000 3f
0 00 0000 00
5 3f 0000 00
3 01 0000 10
0 00 0000 00

//--- fl_mem_top.f
+incdir+src
src/fl_pkg.sv
src/fl_if.sv
src/fl_init_fsm.sv
src/fl_count.sv
src/free_list.sv
src/bank_array.sv
src/fl_mem_top.sv
test/tb_clk_gen.sv
test/tb_fl_mem_top.sv

//--- Makefile
# Verilator build and run for the free-list buffer memory.

TOP       ?= tb_fl_mem_top
FILELIST  ?= fl_mem_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_STR  ?= RESULT: PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard src/*.sv src/*.svh test/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
